// ==== hw/ctrlPkg.sv ====
`default_nettype none

package ctrlPkg;

    // instruction fields
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    // selector widths
    typedef logic [2:0] pcSel_t;
    typedef logic [2:0] addrSel_t;
    typedef logic [1:0] regDstSel_t;
    typedef logic [3:0] m2rSel_t;
    typedef logic [2:0] aluOp_t;
    typedef logic [1:0] srcBSel_t;
    typedef logic [2:0] shiftType_t;
    typedef logic [1:0] shiftQnt_t;
    typedef logic [1:0] shiftReg_t;

    localparam opcode_t OpRType = 6'h00;
    localparam opcode_t OpAddi  = 6'h08;
    localparam opcode_t OpAddiu = 6'h09;
    localparam opcode_t OpLb    = 6'h20;
    localparam opcode_t OpLh    = 6'h21;
    localparam opcode_t OpLw    = 6'h23;
    localparam opcode_t OpSb    = 6'h28;
    localparam opcode_t OpSh    = 6'h29;
    localparam opcode_t OpSw    = 6'h2b;

    localparam funct_t FnSll = 6'h00;
    localparam funct_t FnSrl = 6'h02;
    localparam funct_t FnSra = 6'h03;
    localparam funct_t FnAdd = 6'h20;

    localparam regDstSel_t RegDstRt = 2'd0;
    localparam regDstSel_t RegDstRd = 2'd1;
    localparam regDstSel_t RegDstSp = 2'd3; // $sp (r29)

    localparam m2rSel_t M2rAlu    = 4'd0;
    localparam m2rSel_t M2rWord   = 4'd1;
    localparam m2rSel_t M2rPart   = 4'd2;
    localparam m2rSel_t M2rShift  = 4'd3;
    localparam m2rSel_t M2rSpInit = 4'd7; // constant top-of-stack

    localparam addrSel_t AddrPc     = 3'd0;
    localparam addrSel_t AddrAlu    = 3'd1;
    localparam addrSel_t AddrInvVec = 3'd2;
    localparam addrSel_t AddrOvfVec = 3'd3;

    localparam pcSel_t PcAlu = 3'd0;
    localparam pcSel_t PcMdr = 3'd3;

    localparam aluOp_t AluAdd = 3'd1;
    localparam aluOp_t AluSub = 3'd2;

    localparam srcBSel_t SrcBReg    = 2'd0;
    localparam srcBSel_t SrcBFour   = 2'd1;
    localparam srcBSel_t SrcBImm    = 2'd2;
    localparam srcBSel_t SrcBBranch = 2'd3; // shifted immediate

    localparam shiftType_t ShLoad = 3'd1;
    localparam shiftType_t ShSll  = 3'd2;
    localparam shiftType_t ShSrl  = 3'd3;
    localparam shiftType_t ShSra  = 3'd4;

    localparam shiftQnt_t QntShamt = 2'd1;
    localparam shiftReg_t SrcRegB  = 2'd2;

    typedef enum logic [3:0] {
        ClsAdd, ClsAddi, ClsAddiu,
        ClsLw, ClsLh, ClsLb,
        ClsSw, ClsSh, ClsSb,
        ClsSll, ClsSrl, ClsSra,
        ClsInvalid
    } instrClass_t;

    typedef enum logic [4:0] {
        Boot, SpInit, Fetch, FetchWait, IrLoad, Decode,
        AddExec, AddWrite, ImmExec, ImmWrite,
        AddrCalc, MemRead, MemWait, MdrLoad,
        LoadWord, LoadHalf, LoadByte,
        StoreWord, StoreHalf, StoreByte,
        ShiftLoad, ShiftSll, ShiftSrl, ShiftSra, ShiftWrite,
        ExcInvalid, ExcOverflow, ExcWait, ExcMdr, ExcJump
    } ctrlState_t;

    typedef struct packed {
        logic       pcWrite;
        pcSel_t     pcSrc;
        addrSel_t   iorD;
        logic       memWrite;
        logic       irWrite;
        logic       regWrite;
        regDstSel_t regDst;
        m2rSel_t    memToReg;
        logic       regALoad;
        logic       regBLoad;
        logic       aluSrcA;      // 0 = pc, 1 = reg A
        srcBSel_t   aluSrcB;
        aluOp_t     aluOp;
        logic       aluOutWrite;
        logic       epcWrite;
        logic       mdrLoad;
        logic       wdSrc;        // 1 = merged partial word
        logic       twoBytes;
        logic       store;
        shiftQnt_t  shiftQnt;
        shiftReg_t  shiftReg;
        shiftType_t shiftType;
    } ctrlWord_t;

endpackage

`default_nettype wire

// ==== hw/opDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module opDecoder (
    input  ctrlPkg::opcode_t     opcode,
    input  ctrlPkg::funct_t      funct,
    output ctrlPkg::instrClass_t instrClass
);
    import ctrlPkg::*;

    instrClass_t rClass;

    // R-type goes by funct
    always_comb begin
        case (funct)
            FnAdd:   rClass = ClsAdd;
            FnSll:   rClass = ClsSll;
            FnSrl:   rClass = ClsSrl;
            FnSra:   rClass = ClsSra;
            default: rClass = ClsInvalid;
        endcase
    end

    always_comb begin
        case (opcode)
            OpRType: instrClass = rClass;
            OpAddi:  instrClass = ClsAddi;
            OpAddiu: instrClass = ClsAddiu;
            OpLw:    instrClass = ClsLw;
            OpLh:    instrClass = ClsLh;
            OpLb:    instrClass = ClsLb;
            OpSw:    instrClass = ClsSw;
            OpSh:    instrClass = ClsSh;
            OpSb:    instrClass = ClsSb;
            default: instrClass = ClsInvalid;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/ctrlSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrlSequencer (
    input  logic                 clk,
    input  logic                 rstN,
    input  ctrlPkg::instrClass_t instrClass,
    input  logic                 overflow,
    output ctrlPkg::ctrlState_t  state
);
    import ctrlPkg::*;

    ctrlState_t nextState;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= Boot;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = Boot;
        case (state)
            Boot:      nextState = SpInit;
            SpInit:    nextState = Fetch;
            Fetch:     nextState = FetchWait;
            FetchWait: nextState = IrLoad;
            IrLoad:    nextState = Decode;

            Decode: begin
                case (instrClass)
                    ClsAdd:                          nextState = AddExec;
                    ClsAddi, ClsAddiu:               nextState = ImmExec;
                    ClsLw, ClsLh, ClsLb,
                    ClsSw, ClsSh, ClsSb:             nextState = AddrCalc;
                    ClsSll, ClsSrl, ClsSra:          nextState = ShiftLoad;
                    default:                         nextState = ExcInvalid;
                endcase
            end

            AddExec: nextState = overflow ? ExcOverflow : AddWrite;

            // addiu never traps
            ImmExec: begin
                if (instrClass == ClsAddi && overflow) begin
                    nextState = ExcOverflow;
                end else begin
                    nextState = ImmWrite;
                end
            end

            AddrCalc: nextState = (instrClass == ClsSw) ? StoreWord : MemRead;
            MemRead:  nextState = MemWait;
            MemWait:  nextState = MdrLoad;

            MdrLoad: begin
                case (instrClass)
                    ClsLw:   nextState = LoadWord;
                    ClsLh:   nextState = LoadHalf;
                    ClsLb:   nextState = LoadByte;
                    ClsSh:   nextState = StoreHalf;
                    ClsSb:   nextState = StoreByte;
                    default: nextState = Fetch;
                endcase
            end

            ShiftLoad: begin
                case (instrClass)
                    ClsSrl:  nextState = ShiftSrl;
                    ClsSra:  nextState = ShiftSra;
                    default: nextState = ShiftSll;
                endcase
            end
            ShiftSll, ShiftSrl, ShiftSra: nextState = ShiftWrite;

            ExcInvalid, ExcOverflow: nextState = ExcWait;
            ExcWait:                 nextState = ExcMdr;   // vector word in flight
            ExcMdr:                  nextState = ExcJump;

            AddWrite, ImmWrite,
            LoadWord, LoadHalf, LoadByte,
            StoreWord, StoreHalf, StoreByte,
            ShiftWrite, ExcJump: nextState = Fetch;

            default: nextState = Boot;
        endcase
    end

    stateLegal: assert property (@(posedge clk) disable iff (!rstN)
        state inside {[Boot:ExcJump]})
        else $error("sequencer left the state encoding");

    ovfEntry: assert property (@(posedge clk) disable iff (!rstN)
        state == ExcOverflow |-> $past(state) inside {AddExec, ImmExec})
        else $error("overflow trap taken outside an exec state");

endmodule

`default_nettype wire

// ==== hw/ctrlWordGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrlWordGen (
    input  ctrlPkg::ctrlState_t state,
    output ctrlPkg::ctrlWord_t  ctrl
);
    import ctrlPkg::*;

    always_comb begin
        ctrl = '0;
        case (state)
            SpInit: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = RegDstSp;
                ctrl.memToReg = M2rSpInit;
            end
            Fetch: begin   // pc + 4 while instruction read starts
                ctrl.pcWrite = 1'b1;
                ctrl.pcSrc   = PcAlu;
                ctrl.iorD    = AddrPc;
                ctrl.aluSrcB = SrcBFour;
                ctrl.aluOp   = AluAdd;
            end
            IrLoad: ctrl.irWrite = 1'b1;
            Decode: begin
                ctrl.regALoad    = 1'b1;
                ctrl.regBLoad    = 1'b1;
                ctrl.aluSrcB     = SrcBBranch; // branch target precomputed
                ctrl.aluOp       = AluAdd;
                ctrl.aluOutWrite = 1'b1;
            end
            AddExec: begin
                ctrl.aluSrcA     = 1'b1;
                ctrl.aluSrcB     = SrcBReg;
                ctrl.aluOp       = AluAdd;
                ctrl.aluOutWrite = 1'b1;
            end
            ImmExec, AddrCalc: begin
                ctrl.aluSrcA     = 1'b1;
                ctrl.aluSrcB     = SrcBImm;
                ctrl.aluOp       = AluAdd;
                ctrl.aluOutWrite = 1'b1;
            end
            AddWrite: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = RegDstRd;
                ctrl.memToReg = M2rAlu;
            end
            ImmWrite: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = RegDstRt;
                ctrl.memToReg = M2rAlu;
            end
            MemRead, MemWait: ctrl.iorD = AddrAlu; // hold data address
            MdrLoad, ExcMdr:  ctrl.mdrLoad = 1'b1;
            LoadWord: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = RegDstRt;
                ctrl.memToReg = M2rWord;
            end
            LoadHalf, LoadByte: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = RegDstRt;
                ctrl.memToReg = M2rPart;
                ctrl.twoBytes = (state == LoadHalf);
            end
            StoreWord: begin
                ctrl.memWrite = 1'b1;
                ctrl.iorD     = AddrAlu;
            end
            StoreHalf, StoreByte: begin  // merge into word read earlier
                ctrl.memWrite = 1'b1;
                ctrl.iorD     = AddrAlu;
                ctrl.wdSrc    = 1'b1;
                ctrl.store    = 1'b1;
                ctrl.twoBytes = (state == StoreHalf);
            end
            ShiftLoad: begin
                ctrl.shiftType = ShLoad;
                ctrl.shiftQnt  = QntShamt;
                ctrl.shiftReg  = SrcRegB;
            end
            ShiftSll: ctrl.shiftType = ShSll;
            ShiftSrl: ctrl.shiftType = ShSrl;
            ShiftSra: ctrl.shiftType = ShSra;
            ShiftWrite: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = RegDstRd;
                ctrl.memToReg = M2rShift;
            end
            ExcInvalid, ExcOverflow: begin
                ctrl.epcWrite = 1'b1;
                ctrl.aluOp    = AluSub;
                ctrl.iorD     = (state == ExcInvalid) ? AddrInvVec : AddrOvfVec;
            end
            ExcJump: begin
                ctrl.pcWrite = 1'b1;
                ctrl.pcSrc   = PcMdr;
            end
            default: ctrl = '0; // Boot, FetchWait, ExcWait
        endcase

        // register file and memory never written together
        assert (!(ctrl.regWrite && ctrl.memWrite))
            else $error("regWrite and memWrite both high");
        assert (!ctrl.irWrite || state == IrLoad)
            else $error("irWrite outside IrLoad");
    end

endmodule

`default_nettype wire

// ==== hw/mipsControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module mipsControl (
    input  logic               clk,
    input  logic               rstN,
    input  ctrlPkg::opcode_t   opcode,
    input  ctrlPkg::funct_t    funct,
    input  logic               overflow,
    output ctrlPkg::ctrlWord_t ctrl
);
    import ctrlPkg::*;

    instrClass_t instrClass;
    ctrlState_t  state;

    opDecoder uDecoder (
        .opcode     (opcode),
        .funct      (funct),
        .instrClass (instrClass)
    );

    ctrlSequencer uSequencer (
        .clk        (clk),
        .rstN       (rstN),
        .instrClass (instrClass),
        .overflow   (overflow),
        .state      (state)
    );

    ctrlWordGen uWordGen (
        .state (state),
        .ctrl  (ctrl)
    );

endmodule

`default_nettype wire

// ==== tb/mipsControlTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mipsControlTb;
    import ctrlPkg::*;

    localparam int NumInstr  = 400;
    localparam int MaxCycles = NumInstr * 9 + 50; // longest path is 9 cycles

    logic      clk = 1'b0;
    logic      rstN;
    opcode_t   opcode;
    funct_t    funct;
    logic      overflow;
    ctrlWord_t ctrl;

    ctrlState_t  expState;
    ctrlState_t  pending[$];   // states still ahead for the current instruction
    instrClass_t curKind;
    bit          trapped;
    logic [31:0] rngState;
    int          issued;
    int          cycles;
    int          lastIr;
    int          traps;
    int          errors;
    int          checks;
    bit          finished;
    bit          timedOut;

    mipsControl DUT (
        .clk      (clk),
        .rstN     (rstN),
        .opcode   (opcode),
        .funct    (funct),
        .overflow (overflow),
        .ctrl     (ctrl)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic checkField(input string name, input logic [63:0] expV,
                              input logic [63:0] actV);
        checks++;
        assert (expV == actV) else begin
            errors++;
            $display("[ERROR] %0t %s: expected %0h, got %0h", $time, name, expV, actV);
        end
    endtask

    // expected word built field by field from the state tables
    function automatic ctrlWord_t expectWord(input ctrlState_t s);
        ctrlWord_t w;
        w = '0;
        w.pcWrite  = s inside {Fetch, ExcJump};
        w.pcSrc    = (s == ExcJump) ? PcMdr : PcAlu;
        w.irWrite  = (s == IrLoad);
        w.regWrite = s inside {SpInit, AddWrite, ImmWrite, LoadWord, LoadHalf, LoadByte,
                               ShiftWrite};
        w.regDst   = (s == SpInit) ? RegDstSp :
                     (s inside {AddWrite, ShiftWrite}) ? RegDstRd : RegDstRt;
        w.memWrite = s inside {StoreWord, StoreHalf, StoreByte};
        w.iorD     = (s inside {StoreWord, StoreHalf, StoreByte}) ? AddrAlu :
                     (s == ExcInvalid) ? AddrInvVec :
                     (s == ExcOverflow) ? AddrOvfVec : AddrPc;
        w.memToReg = (s == SpInit) ? M2rSpInit :
                     (s == LoadWord) ? M2rWord :
                     (s inside {LoadHalf, LoadByte}) ? M2rPart :
                     (s == ShiftWrite) ? M2rShift : M2rAlu;
        w.epcWrite = s inside {ExcInvalid, ExcOverflow};
        w.aluOp    = (s == Fetch) ? AluAdd : (w.epcWrite ? AluSub : '0);
        w.aluSrcB  = (s == Fetch) ? SrcBFour : SrcBReg;
        w.regALoad    = (s == Decode);
        w.regBLoad    = (s == Decode);
        w.aluOutWrite = (s == Decode);
        w.wdSrc    = s inside {StoreHalf, StoreByte};
        w.store    = s inside {StoreHalf, StoreByte};
        w.twoBytes = s inside {LoadHalf, StoreHalf};
        w.shiftQnt = (s == ShiftLoad) ? QntShamt : '0;
        w.shiftReg = (s == ShiftLoad) ? SrcRegB : '0;
        w.shiftType = (s == ShiftLoad) ? ShLoad :
                      (s == ShiftSll) ? ShSll :
                      (s == ShiftSrl) ? ShSrl :
                      (s == ShiftSra) ? ShSra : '0;
        return w;
    endfunction

    // states whose whole word is fixed
    function automatic bit fullyNamed(input ctrlState_t s);
        return !(s inside {Decode, AddExec, ImmExec, AddrCalc, MemRead, MemWait, MdrLoad,
                           ExcMdr});
    endfunction

    // fetch-to-fetch cycles per class
    function automatic int gapFor(input instrClass_t kind, input bit trap);
        if (trap) begin
            return 9;
        end
        case (kind)
            ClsAdd, ClsAddi, ClsAddiu, ClsSw:          return 6;
            ClsLw, ClsLh, ClsLb, ClsSh, ClsSb:         return 9;
            ClsSll, ClsSrl, ClsSra:                    return 7;
            default:                                   return 8;
        endcase
    endfunction

    task automatic loadPath();
        pending.delete();
        pending.push_back(Decode);
        if (curKind inside {ClsLw, ClsLh, ClsLb, ClsSw, ClsSh, ClsSb}) begin
            pending.push_back(AddrCalc);
        end
        if (curKind inside {ClsLw, ClsLh, ClsLb, ClsSh, ClsSb}) begin
            pending.push_back(MemRead);
            pending.push_back(MemWait);
            pending.push_back(MdrLoad);
        end
        case (curKind)
            ClsAdd: begin
                pending.push_back(AddExec);
                pending.push_back(AddWrite);
            end
            ClsAddi, ClsAddiu: begin
                pending.push_back(ImmExec);
                pending.push_back(ImmWrite);
            end
            ClsLw:  pending.push_back(LoadWord);
            ClsLh:  pending.push_back(LoadHalf);
            ClsLb:  pending.push_back(LoadByte);
            ClsSw:  pending.push_back(StoreWord);
            ClsSh:  pending.push_back(StoreHalf);
            ClsSb:  pending.push_back(StoreByte);
            ClsSll: pending.push_back(ShiftSll);
            ClsSrl: pending.push_back(ShiftSrl);
            ClsSra: pending.push_back(ShiftSra);
            default: begin
                pending.push_back(ExcInvalid);
                pending.push_back(ExcWait);
                pending.push_back(ExcMdr);
                pending.push_back(ExcJump);
            end
        endcase
        if (curKind inside {ClsSll, ClsSrl, ClsSra}) begin
            pending.push_front(Decode);
            pending[1] = ShiftLoad;     // Decode, ShiftLoad, shift state
            pending.push_back(ShiftWrite);
        end
    endtask

    task automatic pickInstr();
        opcode_t op;
        funct_t  fn;
        int      k;
        rngState = xorshift(rngState);
        k  = int'(rngState % 32'd14);
        op = rngState[13:8];
        fn = rngState[21:16];   // only matters for R-type
        case (k)
            0:  curKind = ClsAdd;
            1:  curKind = ClsAddi;
            2:  curKind = ClsAddiu;
            3:  curKind = ClsLw;
            4:  curKind = ClsLh;
            5:  curKind = ClsLb;
            6:  curKind = ClsSw;
            7:  curKind = ClsSh;
            8:  curKind = ClsSb;
            9:  curKind = ClsSll;
            10: curKind = ClsSrl;
            11: curKind = ClsSra;
            default: curKind = ClsInvalid;
        endcase
        case (k)
            0, 9, 10, 11, 13: op = OpRType;
            1: op = OpAddi;
            2: op = OpAddiu;
            3: op = OpLw;
            4: op = OpLh;
            5: op = OpLb;
            6: op = OpSw;
            7: op = OpSh;
            8: op = OpSb;
            default: begin  // unknown opcode
                while (op inside {OpRType, OpAddi, OpAddiu, OpLb, OpLh, OpLw, OpSb, OpSh,
                                  OpSw}) begin
                    rngState = xorshift(rngState);
                    op = rngState[5:0];
                end
            end
        endcase
        case (k)
            0:  fn = FnAdd;
            9:  fn = FnSll;
            10: fn = FnSrl;
            11: fn = FnSra;
            13: begin  // unknown R-type funct
                while (fn inside {FnSll, FnSrl, FnSra, FnAdd}) begin
                    rngState = xorshift(rngState);
                    fn = rngState[5:0];
                end
            end
            default: ;
        endcase
        opcode <= op;
        funct  <= fn;
        issued++;
        trapped = 1'b0;
        loadPath();
    endtask

    task automatic stepModel(input logic ovfNow);
        if (expState == IrLoad) begin
            pickInstr();    // IR output changes as Decode begins
        end
        case (expState)
            Boot:      expState = SpInit;
            SpInit:    expState = Fetch;
            Fetch:     expState = FetchWait;
            FetchWait: expState = IrLoad;
            default: begin
                if (expState inside {AddExec, ImmExec} && curKind != ClsAddiu && ovfNow) begin
                    pending.delete();
                    pending.push_back(ExcOverflow);
                    pending.push_back(ExcWait);
                    pending.push_back(ExcMdr);
                    pending.push_back(ExcJump);
                    trapped = 1'b1;
                    traps++;
                end
                if (pending.size() > 0) begin
                    expState = pending.pop_front();
                end else begin
                    expState = Fetch;
                end
            end
        endcase
    endtask

    task automatic checkCycle();
        ctrlWord_t e;
        e = expectWord(expState);
        checkField("pcWrite", 64'(e.pcWrite), 64'(ctrl.pcWrite));
        checkField("memWrite", 64'(e.memWrite), 64'(ctrl.memWrite));
        checkField("irWrite", 64'(e.irWrite), 64'(ctrl.irWrite));
        checkField("regWrite", 64'(e.regWrite), 64'(ctrl.regWrite));
        checkField("epcWrite", 64'(e.epcWrite), 64'(ctrl.epcWrite));
        if (expState == Decode) begin
            checkField("regALoad", 64'(e.regALoad), 64'(ctrl.regALoad));
            checkField("regBLoad", 64'(e.regBLoad), 64'(ctrl.regBLoad));
            checkField("aluOutWrite", 64'(e.aluOutWrite), 64'(ctrl.aluOutWrite));
        end
        if (fullyNamed(expState)) begin
            checkField("ctrl", 64'(e), 64'(ctrl));
        end
        if (ctrl.irWrite) begin
            if (lastIr >= 0) begin
                checkField("irWrite spacing", 64'(gapFor(curKind, trapped)),
                           64'(cycles - lastIr));
            end
            lastIr = cycles;
        end
    endtask

    initial begin
        rstN     <= 1'b0;
        opcode   <= '0;
        funct    <= '0;
        overflow <= 1'b0;
        rngState = 32'h344c_c5cb;
        expState = Boot;
        curKind  = ClsInvalid;
        trapped  = 1'b0;
        issued   = 0;
        cycles   = 0;
        lastIr   = -1;
        traps    = 0;
        errors   = 0;
        checks   = 0;
        finished = 1'b0;
        timedOut = 1'b0;

        repeat (16) begin
            @(negedge clk);
            checkField("ctrl", 64'd0, 64'(ctrl)); // all zero in reset
        end
        @(posedge clk);
        rstN <= 1'b1;

        while (!finished && !timedOut) begin
            @(negedge clk);
            checkCycle();
            @(posedge clk);
            cycles++;
            stepModel(overflow);    // value the DUT samples on this edge
            rngState = xorshift(rngState);
            overflow <= rngState[9];
            if (issued == NumInstr && expState == Fetch) begin
                finished = 1'b1;
            end else if (cycles >= MaxCycles) begin
                timedOut = 1'b1;
            end
        end

        if (timedOut) begin
            $display("timeout: %0d instructions not finished after %0d cycles",
                     NumInstr, cycles);
        end
        $display("errors=%0d checks=%0d instructions=%0d overflow traps=%0d",
                 errors, checks, issued, traps);
        if (errors == 0 && !timedOut) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mipsControl.f ====
hw/ctrlPkg.sv
hw/opDecoder.sv
hw/ctrlSequencer.sv
hw/ctrlWordGen.sv
hw/mipsControl.sv
tb/mipsControlTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the mipsControl testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module mipsControlTb \
    -f mipsControl.f -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q '^\*\* PASS \*\*$'; then
    exit 0
fi
exit 1
